// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_flash_sub
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: flash_ctrl.sv
`timescale 1ns/1ps

module flash_ctrl (
	input  logic                                     serial_clk_raw,
	input  logic                                     in_rst,
	input  flash_host_pkg::flash_req_t               req,
	input  logic [flash_host_pkg::word_bits - 1 : 0] wr_head,
	input  logic                                     wr_empty,
	input  logic                                     miso,
	output logic                                     pop,
	output flash_host_pkg::flash_rsp_t               rsp,
	output flash_host_pkg::flash_pins_t              pins
);
	import flash_host_pkg::*;
	import flash_dev_pkg::*;

	typedef enum logic [3:0] {
		st_init, st_reset, st_after_reset,
		st_await_cmd,
		st_cmd_only,
		st_cmd_addr, st_addr,
		st_cmd_wr_one, st_wr_word,
		st_cmd_rd_one, st_rd_word,
		st_read_data, st_write_data,
		st_written, st_erased
	} state_t;

	state_t                       state, next_state;
	state_t                       data_state, next_data_state;
	logic [7:0]                   cmd, next_cmd;
	logic [1:0]                   cmd_phase, next_cmd_phase;
	logic                         is_protected, next_is_protected;
	logic [addr_bits - 1 : 0]     word_ctr, next_word_ctr;
	logic [word_bits - 1 : 0]     word_rx, next_word_rx;
	logic                         word_rdy, next_word_rdy;
	logic [wait_cnt_bits - 1 : 0] wait_ctr, wait_max;
	status_reg_u                  status_q, unlock_word;
	logic [addr_bits - 1 : 0]     addr_shifted;
	logic [word_bits - 1 : 0]     tx_word, rx_word;
	logic                         tx_enable, rx_enable, tx_next, rx_done;
	logic                         sck, mosi;
	logic                         flash_rst, wp_low, ready;

	serial_shifter u_shifter (
		.serial_clk_raw(serial_clk_raw),
		.in_rst(in_rst),
		.tx_enable(tx_enable),
		.rx_enable(rx_enable),
		.tx_word(tx_word),
		.miso(miso),
		.mosi(mosi),
		.sck(sck),
		.rx_word(rx_word),
		.tx_next(tx_next),
		.rx_done(rx_done)
	);

	// address word index 0 is the top byte
	assign addr_shifted = req.addr << (word_bits * word_ctr[1:0]);

	// unlock keeps srp, wel, wip and clears bp
	always_comb begin
		unlock_word = status_q;
		unlock_word.f.bp = '0;
	end

	// ----------------------------------------
	// state registers
	// ----------------------------------------
	always_ff @(posedge serial_clk_raw or posedge in_rst) begin
		if (in_rst) begin
			state <= st_init;
			data_state <= st_await_cmd;
			cmd <= '0;
			cmd_phase <= '0;
			is_protected <= 1'b1;
			word_ctr <= '0;
			word_rx <= '0;
			word_rdy <= 1'b0;
			wait_ctr <= '0;
		end else begin
			state <= next_state;
			data_state <= next_data_state;
			cmd <= next_cmd;
			cmd_phase <= next_cmd_phase;
			is_protected <= next_is_protected;
			word_ctr <= next_word_ctr;
			word_rx <= next_word_rx;
			word_rdy <= next_word_rdy;
			// free running, wraps at the state's limit
			if (wait_ctr == wait_max)
				wait_ctr <= '0;
			else
				wait_ctr <= wait_ctr + 1'b1;
		end
	end

	// status word from the read status step
	always_ff @(posedge serial_clk_raw) begin
		if (state == st_rd_word && rx_done)
			status_q.raw <= rx_word;
	end

	// ----------------------------------------
	// next state logic
	// ----------------------------------------
	always_comb begin
		next_state = state;
		next_data_state = data_state;
		next_cmd = cmd;
		next_cmd_phase = cmd_phase;
		next_is_protected = is_protected;
		next_word_ctr = word_ctr;
		next_word_rx = word_rx;
		next_word_rdy = 1'b0;
		wait_max = '0;
		tx_enable = 1'b0;
		rx_enable = 1'b0;
		tx_word = '0;
		pop = 1'b0;
		flash_rst = 1'b0;
		wp_low = 1'b0;
		ready = 1'b0;

		case (state)
			// power-up waits
			st_init: begin
				wait_max = wait_cnt_bits'(wait_init);
				if (wait_ctr == wait_max)
					next_state = st_reset;
			end
			st_reset: begin
				flash_rst = 1'b1;
				wait_max = wait_cnt_bits'(wait_reset);
				if (wait_ctr == wait_max)
					next_state = st_after_reset;
			end
			st_after_reset: begin
				wait_max = wait_cnt_bits'(wait_after_reset);
				if (wait_ctr == wait_max)
					next_state = st_await_cmd;
			end

			// idle, pick the next command
			st_await_cmd: begin
				if (req.enable) begin
					next_word_ctr = '0;
					if (!req.write && !req.erase) begin
						next_state = st_cmd_addr;
						next_data_state = st_read_data;
						next_cmd = cmd_read;
					end else if (is_protected) begin
						// unlock in three steps before the first change
						next_data_state = st_await_cmd;
						case (cmd_phase)
							2'd0: begin
								next_state = st_cmd_only;
								next_cmd = cmd_write_enable;
								next_cmd_phase = 2'd1;
							end
							2'd1: begin
								next_state = st_cmd_rd_one;
								next_cmd = cmd_read_status;
								next_cmd_phase = 2'd2;
							end
							default: begin
								next_state = st_cmd_wr_one;
								next_cmd = cmd_write_status;
								next_cmd_phase = 2'd0;
								next_is_protected = 1'b0;
							end
						endcase
					end else if (cmd_phase == 2'd0) begin
						// write enable ahead of program or erase
						next_state = st_cmd_only;
						next_data_state = st_await_cmd;
						next_cmd = cmd_write_enable;
						next_cmd_phase = 2'd1;
					end else begin
						next_state = st_cmd_addr;
						next_data_state = req.erase ? st_erased : st_write_data;
						next_cmd = req.erase ? cmd_erase : cmd_write;
						next_cmd_phase = 2'd0;
					end
				end else begin
					ready = 1'b1;
				end
			end

			// single words
			st_cmd_only: begin
				tx_enable = 1'b1;
				tx_word = cmd;
				if (tx_next)
					next_state = data_state;
			end
			st_cmd_wr_one: begin
				tx_enable = 1'b1;
				wp_low = 1'b1;
				tx_word = cmd;
				if (tx_next)
					next_state = st_wr_word;
			end
			st_wr_word: begin
				tx_enable = 1'b1;
				wp_low = 1'b1;
				tx_word = unlock_word.raw;
				if (tx_next)
					next_state = data_state;
			end
			st_cmd_rd_one: begin
				tx_enable = 1'b1;
				tx_word = cmd;
				if (tx_next)
					next_state = st_rd_word;
			end
			st_rd_word: begin
				rx_enable = 1'b1;
				if (rx_done)
					next_state = data_state;
			end

			// command then three address words
			st_cmd_addr: begin
				tx_enable = 1'b1;
				tx_word = cmd;
				if (tx_next) begin
					next_state = st_addr;
					next_word_ctr = '0;
				end
			end
			st_addr: begin
				tx_enable = 1'b1;
				tx_word = addr_shifted[addr_bits - 1 -: word_bits];
				if (tx_next) begin
					if (word_ctr != addr_bits'(addr_words - 1)) begin
						next_word_ctr = word_ctr + 1'b1;
					end else begin
						next_word_ctr = '0;
						next_state = data_state;
					end
				end
			end

			// streaming read, stops at a word boundary
			st_read_data: begin
				rx_enable = 1'b1;
				if (rx_done) begin
					next_word_rx = rx_word;
					next_word_ctr = word_ctr + 1'b1;
					next_word_rdy = 1'b1;
					if (!req.enable)
						next_state = st_await_cmd;
				end
			end

			// streaming write from the fifo head
			st_write_data: begin
				// empty fifo pauses the clock with select held low
				tx_enable = !wr_empty;
				tx_word = wr_head;
				pop = tx_next && !wr_empty;
				if (pop)
					next_word_ctr = word_ctr + 1'b1;
				if (wr_empty && !req.enable)
					next_state = st_written;
			end

			// fixed device busy times
			st_written: begin
				wait_max = wait_cnt_bits'(wait_after_write);
				if (wait_ctr == wait_max)
					next_state = st_await_cmd;
			end
			st_erased: begin
				wait_max = wait_cnt_bits'(wait_after_erase);
				if (wait_ctr == wait_max)
					next_state = st_await_cmd;
			end

			default: next_state = st_init;
		endcase
	end

	// ----------------------------------------
	// outputs
	// ----------------------------------------
	assign pins.rst_n = ~flash_rst;
	assign pins.clk = sck;
	assign pins.select_n = ~(tx_enable | rx_enable | (state == st_write_data));
	assign pins.wp_n = ~wp_low;
	assign pins.mosi = mosi;

	assign rsp.data = word_rx;
	assign rsp.word_ctr = word_ctr;
	assign rsp.word_finished = word_rdy;
	assign rsp.next_word = pop;
	assign rsp.ready = ready;

	// wp_n low only inside a selected write status transfer
	a_wp_idle: assert property (@(posedge serial_clk_raw) disable iff (in_rst)
		!pins.wp_n |-> !pins.select_n && cmd == cmd_write_status);

endmodule

// File: flash_dev_pkg.sv
package flash_dev_pkg;

	// ----------------------------------------
	// device command codes
	// ----------------------------------------
	localparam logic [7:0] cmd_write_status  = 8'h01;
	localparam logic [7:0] cmd_write         = 8'h02;
	localparam logic [7:0] cmd_read          = 8'h03;
	localparam logic [7:0] cmd_write_disable = 8'h04;
	localparam logic [7:0] cmd_read_status   = 8'h05;
	localparam logic [7:0] cmd_write_enable  = 8'h06;
	localparam logic [7:0] cmd_erase         = 8'h81;

	// status register, shifted raw on the wire
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic       srp;
			logic [4:0] bp;
			logic       wel;
			logic       wip;
		} f;
	} status_reg_u;

	// ----------------------------------------
	// scaled wait counts in clocks
	// ----------------------------------------
	localparam int wait_init        = 6;
	localparam int wait_reset       = 2;
	localparam int wait_after_reset = 4;
	localparam int wait_after_write = 10;
	localparam int wait_after_erase = 20;
	// erase wait is the longest one
	localparam int wait_cnt_bits    = $clog2(wait_after_erase + 1);

endpackage

// File: flash_host_pkg.sv
package flash_host_pkg;

	// word and address geometry
	localparam int word_bits     = 8;
	localparam int addr_words    = 3;
	localparam int addr_bits     = word_bits * addr_words;
	localparam int bit_cnt_bits  = $clog2(word_bits);

	// write buffer
	localparam int fifo_depth    = 4;
	localparam int fifo_ptr_bits = $clog2(fifo_depth);
	localparam int fifo_cnt_bits = fifo_ptr_bits + 1;

	// ----------------------------------------
	// host request and response
	// ----------------------------------------
	typedef struct packed {
		logic                     enable;
		logic                     write;
		logic                     erase;
		logic [addr_bits - 1 : 0] addr;
	} flash_req_t;

	typedef struct packed {
		logic [word_bits - 1 : 0] data;
		logic [addr_bits - 1 : 0] word_ctr;
		logic                     word_finished;
		logic                     next_word;
		logic                     ready;
	} flash_rsp_t;

	// flash pin outputs, miso comes in on its own
	typedef struct packed {
		logic rst_n;
		logic clk;
		logic select_n;
		logic wp_n;
		logic mosi;
	} flash_pins_t;

endpackage

// File: flash_sub.sv
`timescale 1ns/1ps

module flash_sub (
	input  logic                                     serial_clk_raw,
	input  logic                                     in_rst,
	input  flash_host_pkg::flash_req_t               req,
	input  logic                                     wr_push,
	input  logic [flash_host_pkg::word_bits - 1 : 0] wr_data,
	input  logic                                     miso,
	output logic                                     wr_full,
	output flash_host_pkg::flash_rsp_t               rsp,
	output flash_host_pkg::flash_pins_t              pins
);
	import flash_host_pkg::*;

	// fifo head and flags toward the controller
	logic [word_bits - 1 : 0] wr_head;
	logic                     wr_empty;
	logic                     wr_pop;

	// host write words wait here
	wr_word_fifo u_fifo (
		.serial_clk_raw(serial_clk_raw),
		.in_rst(in_rst),
		.push(wr_push),
		.push_data(wr_data),
		.pop(wr_pop),
		.head(wr_head),
		.empty(wr_empty),
		.full(wr_full)
	);

	// command sequencer and pins
	flash_ctrl u_ctrl (
		.serial_clk_raw(serial_clk_raw),
		.in_rst(in_rst),
		.req(req),
		.wr_head(wr_head),
		.wr_empty(wr_empty),
		.miso(miso),
		.pop(wr_pop),
		.rsp(rsp),
		.pins(pins)
	);

endmodule

// File: serial_shifter.sv
`timescale 1ns/1ps

module serial_shifter (
	input  logic                                     serial_clk_raw,
	input  logic                                     in_rst,
	input  logic                                     tx_enable,
	input  logic                                     rx_enable,
	input  logic [flash_host_pkg::word_bits - 1 : 0] tx_word,
	input  logic                                     miso,
	output logic                                     mosi,
	output logic                                     sck,
	output logic [flash_host_pkg::word_bits - 1 : 0] rx_word,
	output logic                                     tx_next,
	output logic                                     rx_done
);
	import flash_host_pkg::*;

	logic [bit_cnt_bits - 1 : 0] tx_cnt;
	logic [bit_cnt_bits - 1 : 0] rx_cnt;
	logic [word_bits - 1 : 0]    tx_sh;
	logic [word_bits - 2 : 0]    rx_sh;

	// ----------------------------------------
	// transmit side, falling edge
	// ----------------------------------------
	always_ff @(negedge serial_clk_raw or posedge in_rst) begin
		if (in_rst) begin
			tx_cnt <= '0;
			tx_sh <= '0;
		end else if (tx_enable) begin
			tx_cnt <= tx_cnt + 1'b1;
			// word boundary, take the new word
			if (tx_cnt == '0)
				tx_sh <= tx_word;
			else
				tx_sh <= tx_sh << 1;
		end else begin
			// idle, mosi back to 0
			tx_cnt <= '0;
			tx_sh <= '0;
		end
	end

	// msb first
	assign mosi = tx_sh[word_bits - 1];

	// ----------------------------------------
	// receive side, rising edge
	// ----------------------------------------
	always_ff @(posedge serial_clk_raw or posedge in_rst) begin
		if (in_rst) begin
			rx_cnt <= '0;
			tx_next <= 1'b0;
		end else begin
			// high for the clock that carries the last tx bit
			tx_next <= tx_enable && (tx_cnt == bit_cnt_bits'(word_bits - 1));
			if (rx_enable)
				rx_cnt <= rx_cnt + 1'b1;
			else
				rx_cnt <= '0;
		end
	end

	always_ff @(posedge serial_clk_raw) begin
		if (rx_enable)
			rx_sh <= {rx_sh[word_bits - 3 : 0], miso};
	end

	// last bit comes straight from the pin
	assign rx_word = {rx_sh, miso};
	assign rx_done = rx_enable && (rx_cnt == bit_cnt_bits'(word_bits - 1));

	// clock runs only while a word moves, idles high
	assign sck = (tx_enable || rx_enable) ? serial_clk_raw : 1'b1;

	// the controller never drives both directions
	a_one_direction: assert property (@(posedge serial_clk_raw) disable iff (in_rst)
		!(tx_enable && rx_enable));

endmodule

// File: tb.f
flash_dev_pkg.sv
flash_host_pkg.sv
serial_shifter.sv
wr_word_fifo.sv
flash_ctrl.sv
flash_sub.sv
tb_flash_model.sv
tb_flash_sub.sv

// File: tb_flash_model.sv
`timescale 1ns/1ps

module tb_flash_model (
	input  flash_host_pkg::flash_pins_t pins,
	output logic                        miso,
	output logic                        proto_error
);
	import flash_host_pkg::*;
	import flash_dev_pkg::*;

	logic [7:0]  mem [64];
	status_reg_u status;
	logic [7:0]  sh;
	logic [7:0]  cur_cmd;
	logic [23:0] addr;
	logic [7:0]  cmd_log [$];
	int          nbits;
	int          programmed;

	initial begin
		for (int i = 0; i < 64; i++)
			mem[i] = 8'hff;
		// block protect set out of reset
		status.raw = 8'h1c;
		sh = '0;
		cur_cmd = '0;
		addr = '0;
		nbits = 0;
		programmed = 0;
		miso = 1'b0;
		proto_error = 1'b0;
	end

	task automatic flag_violation(input string what);
		$display("flash model: %s", what);
		proto_error = 1'b1;
	endtask

	// one complete byte, idx counts from the command byte
	task automatic take_byte(input int idx, input logic [7:0] b);
		logic [5:0] wr_idx;
		wr_idx = 6'(int'(addr[5:0]) + idx - 4);
		if (idx == 0) begin
			cur_cmd = b;
			cmd_log.push_back(b);
			if (b == cmd_write_enable)
				status.f.wel = 1'b1;
			else if (b == cmd_write_disable)
				status.f.wel = 1'b0;
			else if (b == cmd_write || b == cmd_erase) begin
				a_unlocked: assert (status.f.bp == '0 && status.f.wel)
					else flag_violation("program or erase while protected");
			end
		end else if (cur_cmd == cmd_write_status) begin
			if (idx == 1) begin
				a_wp_low: assert (!pins.wp_n)
					else flag_violation("write status with wp_n high");
				status.f.srp = b[7];
				status.f.bp = b[6:2];
			end
		end else if (idx <= 3) begin
			addr = {addr[15:0], b};
			// erase acts on one byte once the address is complete
			if (idx == 3 && cur_cmd == cmd_erase)
				mem[addr[5:0]] = 8'hff;
		end else if (cur_cmd == cmd_write) begin
			// program only clears bits
			mem[wr_idx] = mem[wr_idx] & b;
			programmed = programmed + 1;
		end
	endtask

	// ----------------------------------------
	// command decode on rising sck
	// ----------------------------------------
	always @(posedge pins.clk) begin : rx_bits
		logic [7:0] in_byte;
		if (!pins.select_n && pins.rst_n) begin
			in_byte = {sh[6:0], pins.mosi};
			sh = in_byte;
			if (nbits % 8 == 7)
				take_byte(nbits / 8, in_byte);
			nbits = nbits + 1;
		end
	end

	// end of a transfer, write latch drops after a change
	always @(posedge pins.select_n) begin
		if (cur_cmd == cmd_write_status || cur_cmd == cmd_write || cur_cmd == cmd_erase)
			status.f.wel = 1'b0;
		nbits = 0;
		cur_cmd = '0;
	end

	// read data out on falling sck
	always @(negedge pins.clk) begin : tx_bits
		logic [2:0] bit_pos;
		logic [5:0] rd_idx;
		bit_pos = 3'(7 - nbits % 8);
		rd_idx = 6'(int'(addr[5:0]) + (nbits - 32) / 8);
		if (!pins.select_n) begin
			if (cur_cmd == cmd_read_status && nbits >= 8)
				miso <= status.raw[bit_pos];
			else if (cur_cmd == cmd_read && nbits >= 32)
				miso <= mem[rd_idx][bit_pos];
		end
	end

endmodule

// File: tb_flash_sub.sv
`timescale 1ns/1ps

module tb_flash_sub;
	import flash_host_pkg::*;
	import flash_dev_pkg::*;

	logic        serial_clk_raw;
	logic        in_rst;
	flash_req_t  req;
	logic        wr_push;
	logic [7:0]  wr_data;
	logic        miso;
	logic        wr_full;
	flash_rsp_t  rsp;
	flash_pins_t pins;
	logic        proto_error;
	logic [7:0]  exp_data [4];
	logic [23:0] wr_addr;
	int          seed;
	logic        saw_rst;

	flash_sub DUT (
		.serial_clk_raw(serial_clk_raw),
		.in_rst(in_rst),
		.req(req),
		.wr_push(wr_push),
		.wr_data(wr_data),
		.miso(miso),
		.wr_full(wr_full),
		.rsp(rsp),
		.pins(pins)
	);

	tb_flash_model u_model (
		.pins(pins),
		.miso(miso),
		.proto_error(proto_error)
	);

	initial serial_clk_raw = 1'b0;
	always #20 serial_clk_raw = ~serial_clk_raw;

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	always @(negedge serial_clk_raw) begin
		if (proto_error)
			stop_with_error("flash model flagged a protocol violation");
	end

	// ----------------------------------------
	// host side helpers
	// ----------------------------------------
	task automatic push_word(input logic [7:0] b);
		int n;
		n = 0;
		// hold off while the buffer is full
		do begin
			@(negedge serial_clk_raw);
			n++;
			if (n > 500)
				stop_with_error("timeout waiting for wr_full to drop");
		end while (wr_full);
		@(posedge serial_clk_raw);
		wr_push <= 1'b1;
		wr_data <= b;
		@(posedge serial_clk_raw);
		wr_push <= 1'b0;
	endtask

	// enable drops once the model has the command byte
	task automatic run_change(input logic erase, input logic [23:0] a, input int nwords);
		int n;
		int pulses;
		int done_ctr;
		int bound;
		logic dropped;
		n = 0;
		pulses = 0;
		dropped = 1'b0;
		done_ctr = u_model.programmed;
		bound = erase ? wait_after_erase + 2 : wait_after_write + 2;
		@(posedge serial_clk_raw);
		req <= '{enable: 1'b1, write: !erase, erase: erase, addr: a};
		while (!dropped || !pins.select_n) begin
			@(negedge serial_clk_raw);
			n++;
			if (n > 600)
				stop_with_error("timeout waiting for the change command to finish");
			if (rsp.next_word)
				pulses++;
			if (!dropped && u_model.cur_cmd == (erase ? cmd_erase : cmd_write)) begin
				dropped = 1'b1;
				@(posedge serial_clk_raw);
				req.enable <= 1'b0;
			end
		end
		// device busy time after select_n rises
		n = 0;
		while (!rsp.ready) begin
			@(negedge serial_clk_raw);
			n++;
			if (n > 100)
				stop_with_error("timeout waiting for ready after the change command");
		end
		a_busy_bound: assert (n <= bound)
			else stop_with_error($sformatf("ERROR: ready delay 0x%h above 0x%h", n, bound));
		a_next_word: assert (pulses == (erase ? 0 : nwords))
			else stop_with_error($sformatf("ERROR: next_word count 0x%h expected 0x%h",
				pulses, nwords));
		a_programmed: assert (u_model.programmed - done_ctr == (erase ? 0 : nwords))
			else stop_with_error($sformatf("ERROR: programmed 0x%h expected 0x%h",
				u_model.programmed - done_ctr, nwords));
	endtask

	task automatic run_read(input logic [23:0] a, input int nwords);
		int n;
		int k;
		n = 0;
		k = 0;
		@(posedge serial_clk_raw);
		req <= '{enable: 1'b1, write: 1'b0, erase: 1'b0, addr: a};
		do begin
			@(negedge serial_clk_raw);
			n++;
			if (n > 600)
				stop_with_error("timeout waiting for the read to finish");
			if (rsp.word_finished) begin
				a_rd_data: assert (rsp.data == exp_data[k])
					else stop_with_error($sformatf("ERROR: rsp.data 0x%h expected 0x%h",
						rsp.data, exp_data[k]));
				a_rd_ctr: assert (rsp.word_ctr == 24'(k + 1))
					else stop_with_error($sformatf("ERROR: rsp.word_ctr 0x%h expected 0x%h",
						rsp.word_ctr, k + 1));
				k++;
			end
			// stop at the boundary of the last word
			if (req.enable && u_model.cur_cmd == cmd_read && k >= nwords - 1) begin
				@(posedge serial_clk_raw);
				req.enable <= 1'b0;
			end
		end while (!rsp.ready || req.enable);
		a_rd_words: assert (k == nwords)
			else stop_with_error($sformatf("ERROR: word_finished count 0x%h expected 0x%h",
				k, nwords));
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		int n;
		logic [7:0] word;
		in_rst = 1'b1;
		req = '0;
		wr_push = 1'b0;
		wr_data = '0;
		saw_rst = 1'b0;
		seed = 32'hf6f0_3e33;
		repeat (16) @(posedge serial_clk_raw);
		in_rst <= 1'b0;

		// power-up, select stays high until ready
		n = 0;
		do begin
			@(negedge serial_clk_raw);
			n++;
			if (n > wait_init + wait_reset + wait_after_reset + 20)
				stop_with_error("timeout waiting for ready after power-up");
			if (!pins.rst_n)
				saw_rst = 1'b1;
			a_sel_idle: assert (pins.select_n)
				else stop_with_error("select_n went low before the first operation");
		end while (!rsp.ready);
		a_saw_rst: assert (saw_rst)
			else stop_with_error("ready rose without a device reset pulse");

		// first write goes through unlock
		wr_addr = 24'(6'($random(seed)));
		for (int i = 0; i < 4; i++) begin
			word = 8'($random(seed));
			push_word(word);
			// memory starts erased, program only clears bits
			exp_data[i] = 8'hff & word;
		end
		run_change(1'b0, wr_addr, 4);
		a_unlock_seq: assert (u_model.cmd_log[0] == cmd_write_enable
			&& u_model.cmd_log[1] == cmd_read_status
			&& u_model.cmd_log[2] == cmd_write_status
			&& u_model.cmd_log[3] == cmd_write_enable
			&& u_model.cmd_log[4] == cmd_write)
			else stop_with_error("unlock command sequence is wrong");

		// read back the programmed words
		run_read(wr_addr, 4);

		// erase one byte then read it
		run_change(1'b1, wr_addr, 0);
		exp_data[0] = 8'hff;
		run_read(wr_addr, 1);

		// buffer fills after four words
		for (int i = 0; i < 4; i++)
			push_word(8'($random(seed)));
		@(negedge serial_clk_raw);
		a_full: assert (wr_full)
			else stop_with_error($sformatf("ERROR: wr_full 0x%h expected 0x1", wr_full));
		run_change(1'b0, wr_addr + 24'd16, 4);

		$display("Test completed successfully");
		$finish;
	end

endmodule

// File: wr_word_fifo.sv
`timescale 1ns/1ps

module wr_word_fifo (
	input  logic                                     serial_clk_raw,
	input  logic                                     in_rst,
	input  logic                                     push,
	input  logic [flash_host_pkg::word_bits - 1 : 0] push_data,
	input  logic                                     pop,
	output logic [flash_host_pkg::word_bits - 1 : 0] head,
	output logic                                     empty,
	output logic                                     full
);
	import flash_host_pkg::*;

	logic [word_bits - 1 : 0]     mem [fifo_depth];
	logic [fifo_ptr_bits - 1 : 0] wr_ptr;
	logic [fifo_ptr_bits - 1 : 0] rd_ptr;
	logic [fifo_cnt_bits - 1 : 0] count;
	logic                         push_ok;
	logic                         pop_ok;

	// push on full is dropped
	assign push_ok = push && !full;
	assign pop_ok = pop && !empty;

	// ----------------------------------------
	// storage and pointers
	// ----------------------------------------
	always_ff @(posedge serial_clk_raw) begin
		if (push_ok)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge serial_clk_raw or posedge in_rst) begin
		if (in_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			// pointers wrap on their own, depth is a power of two
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push_ok, pop_ok})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// first word falls through
	assign head = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = (count == fifo_cnt_bits'(fifo_depth));

	a_no_drop: assert property (@(posedge serial_clk_raw) disable iff (in_rst)
		push |-> !full) else $error("wr_word_fifo push while full, word dropped");
	a_no_underrun: assert property (@(posedge serial_clk_raw) disable iff (in_rst)
		pop |-> !empty) else $error("wr_word_fifo pop while empty");

endmodule
